// File: build.f
+incdir+logic
+incdir+verification
logic/bp_pkg.sv
logic/btb_table.sv
logic/gshare_pht.sv
logic/fetch_predictor.sv
logic/predict_queue.sv
logic/resolve_unit.sv
logic/branch_predictor_top.sv
verification/tb_branch_predictor.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_branch_predictor \
    -f build.f > "$LOG" 2>&1 &&
    ./obj_dir/Vtb_branch_predictor >> "$LOG" 2>&1 ||
    echo "SOME TESTS FAILED" >> "$LOG"
cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && exit 1 || exit 0

// File: verification/bp_ref_model.svh
// Branch predictor reference model
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

localparam int MDL_PHT_SIZE = 1 << `BP_GHR_BITS;

logic                    mdl_btb_valid  [`BP_BTB_ENTRIES];
logic [31:0]             mdl_btb_tag    [`BP_BTB_ENTRIES];
bp_pkg::instr_class_e    mdl_btb_class  [`BP_BTB_ENTRIES];
logic [31:0]             mdl_btb_target [`BP_BTB_ENTRIES];
logic [1:0]              mdl_cnt        [MDL_PHT_SIZE];
logic [`BP_GHR_BITS-1:0] mdl_ghr;

// In-flight predictions, oldest at index 0
logic [31:0]             fl_pc     [$];
bp_pkg::instr_class_e    fl_class  [$];
logic [`BP_GHR_BITS-1:0] fl_index  [$];
logic                    fl_taken  [$];
logic [31:0]             fl_target [$];

logic                    exp_mispredict;
logic [31:0]             exp_redirect;

function automatic void model_reset();
    for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
        mdl_btb_valid[i] = 1'b0;
    end
    for (int i = 0; i < MDL_PHT_SIZE; i++) begin
        mdl_cnt[i] = 2'b01;
    end
    mdl_ghr = '0;
    fl_pc.delete();
    fl_class.delete();
    fl_index.delete();
    fl_taken.delete();
    fl_target.delete();
    exp_mispredict = 1'b0;
    exp_redirect   = '0;
endfunction

function automatic bp_pkg::instr_class_e opcode_class(input logic [6:0] op);
    case (op)
        bp_pkg::OPC_BRANCH: return bp_pkg::CLASS_BRANCH;
        bp_pkg::OPC_JAL:    return bp_pkg::CLASS_JUMP;
        bp_pkg::OPC_JALR:   return bp_pkg::CLASS_JUMP;
        default:            return bp_pkg::CLASS_NONE;
    endcase
endfunction

function automatic void model_predict(input logic [31:0] pc, output logic taken,
                                      output logic [31:0] target,
                                      output logic [`BP_GHR_BITS-1:0] index);
    logic hit;
    hit   = mdl_btb_valid[pc[5:2]] && (mdl_btb_tag[pc[5:2]] == pc);
    index = pc[`BP_GHR_BITS+1:2] ^ mdl_ghr;
    taken = 1'b0;
    if (hit && mdl_btb_class[pc[5:2]] == bp_pkg::CLASS_JUMP) begin
        taken = 1'b1;
    end else if (hit && mdl_btb_class[pc[5:2]] == bp_pkg::CLASS_BRANCH) begin
        taken = mdl_cnt[index][1];
    end
    target = taken ? mdl_btb_target[pc[5:2]] : pc + 32'd4;
endfunction

// Advances the model by one clock edge; prediction uses the state before it
function automatic void model_step(input logic fv, input logic [31:0] pc, input logic [6:0] op,
                                   input logic rv, input logic rtaken,
                                   input logic [31:0] rtarget);
    bp_pkg::instr_class_e    cls;
    logic                    p_taken;
    logic [31:0]             p_target;
    logic [`BP_GHR_BITS-1:0] p_index;
    logic                    do_push;
    logic                    miss;
    logic                    hist_bit;
    logic [`BP_GHR_BITS-1:0] c;
    cls = opcode_class(op);
    model_predict(pc, p_taken, p_target, p_index);
    do_push = fv && (cls != bp_pkg::CLASS_NONE) && (fl_pc.size() < `BP_QUEUE_DEPTH);
    miss = 1'b0;
    if (rv) begin
        miss = (fl_taken[0] != rtaken) || (fl_taken[0] && rtaken && fl_target[0] != rtarget);
        c = fl_index[0];
        if (fl_class[0] == bp_pkg::CLASS_BRANCH) begin
            if (rtaken && mdl_cnt[c] != 2'b11) begin
                mdl_cnt[c] = mdl_cnt[c] + 2'd1;
            end else if (!rtaken && mdl_cnt[c] != 2'b00) begin
                mdl_cnt[c] = mdl_cnt[c] - 2'd1;
            end
        end
        hist_bit = (fl_class[0] == bp_pkg::CLASS_JUMP) ? 1'b1 : rtaken;
        mdl_ghr  = {mdl_ghr[`BP_GHR_BITS-2:0], hist_bit};
        if (rtaken && (!fl_taken[0] || fl_target[0] != rtarget)) begin
            mdl_btb_valid[fl_pc[0][5:2]]  = 1'b1;
            mdl_btb_tag[fl_pc[0][5:2]]    = fl_pc[0];
            mdl_btb_class[fl_pc[0][5:2]]  = fl_class[0];
            mdl_btb_target[fl_pc[0][5:2]] = rtarget;
        end
        if (miss) begin
            exp_redirect = rtaken ? rtarget : fl_pc[0] + 32'd4;
        end
        fl_pc.delete(0);
        fl_class.delete(0);
        fl_index.delete(0);
        fl_taken.delete(0);
        fl_target.delete(0);
        // Wrong-path entries go away with the mispredict
        if (miss) begin
            fl_pc.delete();
            fl_class.delete();
            fl_index.delete();
            fl_taken.delete();
            fl_target.delete();
        end
    end
    exp_mispredict = miss;
    if (do_push && !miss) begin
        fl_pc.push_back(pc);
        fl_class.push_back(cls);
        fl_index.push_back(p_index);
        fl_taken.push_back(p_taken);
        fl_target.push_back(p_target);
    end
endfunction

`endif

// File: verification/tb_branch_predictor.sv
// Branch predictor testbench
`timescale 1ns/1ps
`include "bp_macros.svh"

module tb_branch_predictor;

    localparam int POOL    = 8;
    localparam int CYCLES  = 600;
    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst_n_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_pc_i;
    logic [6:0]  fetch_op_i;
    logic        fetch_ready_o;
    logic        pred_taken_o;
    logic [31:0] pred_target_o;
    logic        resolve_valid_i;
    logic        resolve_taken_i;
    logic [31:0] resolve_target_i;
    logic        queue_empty_o;
    logic        mispredict_o;
    logic [31:0] redirect_pc_o;

    integer      seed;
    logic [31:0] pc_pool [POOL];
    logic [6:0]  op_pool [POOL];

    `include "bp_ref_model.svh"

    branch_predictor_top branch_predictor_top_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_op_i       (fetch_op_i),
        .fetch_ready_o    (fetch_ready_o),
        .pred_taken_o     (pred_taken_o),
        .pred_target_o    (pred_target_o),
        .resolve_valid_i  (resolve_valid_i),
        .resolve_taken_i  (resolve_taken_i),
        .resolve_target_i (resolve_target_i),
        .queue_empty_o    (queue_empty_o),
        .mispredict_o     (mispredict_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    always #10 clk = ~clk;

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("Fail at %0d ns: %s got 0x%h, expected 0x%h", $time, name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1, "Mismatch on %s", name);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0d ns while waiting for %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
    endtask

    task automatic check_outputs(input logic [31:0] pc);
        logic                    e_taken;
        logic [31:0]             e_target;
        logic [`BP_GHR_BITS-1:0] e_index;
        model_predict(pc, e_taken, e_target, e_index);
        assert (pred_taken_o == e_taken)
            else report_value("pred_taken_o", 32'(pred_taken_o), 32'(e_taken));
        assert (pred_target_o == e_target)
            else report_value("pred_target_o", pred_target_o, e_target);
        assert (queue_empty_o == (fl_pc.size() == 0))
            else report_value("queue_empty_o", 32'(queue_empty_o), 32'(fl_pc.size() == 0));
        assert (fetch_ready_o == (fl_pc.size() < `BP_QUEUE_DEPTH))
            else report_value("fetch_ready_o", 32'(fetch_ready_o),
                              32'(fl_pc.size() < `BP_QUEUE_DEPTH));
        assert (mispredict_o == exp_mispredict)
            else report_value("mispredict_o", 32'(mispredict_o), 32'(exp_mispredict));
        if (exp_mispredict) begin
            assert (redirect_pc_o == exp_redirect)
                else report_value("redirect_pc_o", redirect_pc_o, exp_redirect);
        end
    endtask

    // Drive after the edge, check mid-cycle, then advance the model by one clock
    task automatic run_cycle(input logic fv, input int sel, input logic rv,
                             input logic rtaken, input logic [31:0] rtarget);
        @(posedge clk);
        #1;
        fetch_valid_i    = fv;
        fetch_pc_i       = pc_pool[sel];
        fetch_op_i       = op_pool[sel];
        resolve_valid_i  = rv;
        resolve_taken_i  = rtaken;
        resolve_target_i = rtarget;
        #8;
        check_outputs(pc_pool[sel]);
        model_step(fv, pc_pool[sel], op_pool[sel], rv, rtaken, rtarget);
    endtask

    // Jumps are always taken; branches lean by PC bit 2; rarely a new target
    task automatic resolve_outcome(output logic taken, output logic [31:0] target);
        int r;
        r = $unsigned($random(seed)) % 8;
        if (fl_class[0] == bp_pkg::CLASS_JUMP) begin
            taken = 1'b1;
        end else if (fl_pc[0][2]) begin
            taken = (r < 2);
        end else begin
            taken = (r >= 2);
        end
        target = (r == 7) ? fl_pc[0] + 32'h800 : fl_pc[0] + 32'h400;
    endtask

    task automatic random_cycle();
        int          sel;
        logic        fv;
        logic        rv;
        logic        rtaken;
        logic [31:0] rtarget;
        sel     = $unsigned($random(seed)) % POOL;
        fv      = ($unsigned($random(seed)) % 4 != 0) && (fl_pc.size() < `BP_QUEUE_DEPTH);
        rv      = ($unsigned($random(seed)) % 3 == 0) && (fl_pc.size() != 0);
        rtaken  = 1'b0;
        rtarget = '0;
        if (rv) begin
            resolve_outcome(rtaken, rtarget);
        end
        run_cycle(fv, sel, rv, rtaken, rtarget);
    endtask

    task automatic drain_queue();
        int          waited;
        logic        rtaken;
        logic [31:0] rtarget;
        waited = 0;
        while (fl_pc.size() != 0) begin
            if (waited == TIMEOUT) begin
                report_timeout("the in-flight list to drain");
            end
            resolve_outcome(rtaken, rtarget);
            run_cycle(1'b0, 0, 1'b1, rtaken, rtarget);
            waited++;
        end
        waited = 0;
        while (queue_empty_o !== 1'b1 || mispredict_o !== 1'b0) begin
            if (waited == TIMEOUT) begin
                report_timeout("queue_empty_o after the drain");
            end
            run_cycle(1'b0, 0, 1'b0, 1'b0, 32'h0);
            waited++;
        end
    endtask

    initial begin
        seed = 32'hbae9_85b7;
        for (int i = 0; i < POOL; i++) begin
            // Two PCs alias the low ones in BTB and PHT index
            pc_pool[i] = (i < 6) ? 32'h1000 + 32'(i) * 4 : 32'h2000 + 32'(i - 6) * 4;
            case (i % 4)
                0, 1:    op_pool[i] = bp_pkg::OPC_BRANCH;
                2:       op_pool[i] = bp_pkg::OPC_JAL;
                default: op_pool[i] = bp_pkg::OPC_JALR;
            endcase
        end
        op_pool[5] = 7'b0110011;
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        fetch_valid_i    = 1'b0;
        fetch_pc_i       = pc_pool[0];
        fetch_op_i       = op_pool[0];
        resolve_valid_i  = 1'b0;
        resolve_taken_i  = 1'b0;
        resolve_target_i = '0;
        model_reset();
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        #8;
        check_outputs(pc_pool[0]);

        // Cold tables predict fall-through everywhere
        for (int i = 0; i < POOL; i++) begin
            run_cycle(1'b0, i, 1'b0, 1'b0, 32'h0);
            assert (pred_target_o == pc_pool[i] + 32'd4)
                else report_value("pred_target_o", pred_target_o, pc_pool[i] + 32'd4);
        end

        // A resolved jal is taken to its target from then on
        run_cycle(1'b1, 2, 1'b0, 1'b0, 32'h0);
        run_cycle(1'b0, 2, 1'b1, 1'b1, pc_pool[2] + 32'h400);
        run_cycle(1'b0, 2, 1'b0, 1'b0, 32'h0);
        assert (pred_taken_o == 1'b1)
            else report_value("pred_taken_o", 32'(pred_taken_o), 32'h1);
        assert (pred_target_o == pc_pool[2] + 32'h400)
            else report_value("pred_target_o", pred_target_o, pc_pool[2] + 32'h400);

        // Fill to four in flight, then flush on a stale jump target
        run_cycle(1'b1, 2, 1'b0, 1'b0, 32'h0);
        run_cycle(1'b1, 3, 1'b0, 1'b0, 32'h0);
        run_cycle(1'b1, 0, 1'b0, 1'b0, 32'h0);
        run_cycle(1'b1, 1, 1'b0, 1'b0, 32'h0);
        run_cycle(1'b0, 0, 1'b0, 1'b0, 32'h0);
        assert (fetch_ready_o == 1'b0)
            else report_value("fetch_ready_o", 32'(fetch_ready_o), 32'h0);
        run_cycle(1'b0, 0, 1'b1, 1'b1, pc_pool[2] + 32'h800);
        run_cycle(1'b0, 0, 1'b0, 1'b0, 32'h0);
        run_cycle(1'b0, 0, 1'b0, 1'b0, 32'h0);

        // Same branch resolved taken over and over saturates its counter
        for (int i = 0; i < 12; i++) begin
            run_cycle(1'b1, 0, 1'b0, 1'b0, 32'h0);
            run_cycle(1'b0, 0, 1'b1, 1'b1, pc_pool[0] + 32'h400);
        end

        repeat (CYCLES) random_cycle();
        drain_queue();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: logic/branch_predictor_top.sv
// Branch prediction front end
`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_predictor_top (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        fetch_valid_i,
    input  logic [31:0] fetch_pc_i,
    input  logic [6:0]  fetch_op_i,
    output logic        fetch_ready_o,
    output logic        pred_taken_o,
    output logic [31:0] pred_target_o,
    input  logic        resolve_valid_i,
    input  logic        resolve_taken_i,
    input  logic [31:0] resolve_target_i,
    output logic        queue_empty_o,
    output logic        mispredict_o,
    output logic [31:0] redirect_pc_o
);

    logic                    push;
    logic [31:0]             push_pc;
    bp_pkg::instr_class_e    push_class;
    logic [`BP_GHR_BITS-1:0] push_index;
    logic                    push_taken;
    logic [31:0]             push_target;
    logic                    queue_full;
    logic                    pop;
    logic                    flush;
    logic [31:0]             head_pc;
    bp_pkg::instr_class_e    head_class;
    logic [`BP_GHR_BITS-1:0] head_index;
    logic                    head_taken;
    logic [31:0]             head_target;
    logic                    btb_wr_en;
    bp_pkg::instr_class_e    btb_wr_class;
    logic [31:0]             btb_wr_target;
    logic                    pht_upd_en;
    logic [`BP_GHR_BITS-1:0] pht_upd_index;
    logic                    pht_upd_taken;
    logic                    pht_upd_is_branch;

    fetch_predictor fetch_predictor_inst (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .fetch_valid_i       (fetch_valid_i),
        .fetch_pc_i          (fetch_pc_i),
        .fetch_op_i          (fetch_op_i),
        .fetch_ready_o       (fetch_ready_o),
        .pred_taken_o        (pred_taken_o),
        .pred_target_o       (pred_target_o),
        .push_o              (push),
        .push_pc_o           (push_pc),
        .push_class_o        (push_class),
        .push_index_o        (push_index),
        .push_taken_o        (push_taken),
        .push_target_o       (push_target),
        .queue_full_i        (queue_full),
        .btb_wr_en_i         (btb_wr_en),
        .btb_wr_pc_i         (head_pc),
        .btb_wr_class_i      (btb_wr_class),
        .btb_wr_target_i     (btb_wr_target),
        .pht_upd_en_i        (pht_upd_en),
        .pht_upd_index_i     (pht_upd_index),
        .pht_upd_taken_i     (pht_upd_taken),
        .pht_upd_is_branch_i (pht_upd_is_branch)
    );

    predict_queue predict_queue_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .push_i        (push),
        .push_pc_i     (push_pc),
        .push_class_i  (push_class),
        .push_index_i  (push_index),
        .push_taken_i  (push_taken),
        .push_target_i (push_target),
        .pop_i         (pop),
        .flush_i       (flush),
        .full_o        (queue_full),
        .empty_o       (queue_empty_o),
        .head_pc_o     (head_pc),
        .head_class_o  (head_class),
        .head_index_o  (head_index),
        .head_taken_o  (head_taken),
        .head_target_o (head_target)
    );

    resolve_unit resolve_unit_inst (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .resolve_valid_i     (resolve_valid_i),
        .resolve_taken_i     (resolve_taken_i),
        .resolve_target_i    (resolve_target_i),
        .head_pc_i           (head_pc),
        .head_class_i        (head_class),
        .head_index_i        (head_index),
        .head_taken_i        (head_taken),
        .head_target_i       (head_target),
        .pop_o               (pop),
        .flush_o             (flush),
        .btb_wr_en_o         (btb_wr_en),
        .btb_wr_class_o      (btb_wr_class),
        .btb_wr_target_o     (btb_wr_target),
        .pht_upd_en_o        (pht_upd_en),
        .pht_upd_index_o     (pht_upd_index),
        .pht_upd_taken_o     (pht_upd_taken),
        .pht_upd_is_branch_o (pht_upd_is_branch),
        .mispredict_o        (mispredict_o),
        .redirect_pc_o       (redirect_pc_o)
    );

endmodule

// File: logic/resolve_unit.sv
// Branch resolution and training
`timescale 1ns/1ps
`include "bp_macros.svh"

module resolve_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    resolve_valid_i,
    input  logic                    resolve_taken_i,
    input  logic [31:0]             resolve_target_i,
    input  logic [31:0]             head_pc_i,
    input  bp_pkg::instr_class_e    head_class_i,
    input  logic [`BP_GHR_BITS-1:0] head_index_i,
    input  logic                    head_taken_i,
    input  logic [31:0]             head_target_i,
    output logic                    pop_o,
    output logic                    flush_o,
    output logic                    btb_wr_en_o,
    output bp_pkg::instr_class_e    btb_wr_class_o,
    output logic [31:0]             btb_wr_target_o,
    output logic                    pht_upd_en_o,
    output logic [`BP_GHR_BITS-1:0] pht_upd_index_o,
    output logic                    pht_upd_taken_o,
    output logic                    pht_upd_is_branch_o,
    output logic                    mispredict_o,
    output logic [31:0]             redirect_pc_o
);

    logic target_diff;
    logic mispredict;
    logic actual_taken;

    // Jumps always count as taken in the history
    assign actual_taken = (head_class_i == bp_pkg::CLASS_JUMP) || resolve_taken_i;
    assign target_diff  = (head_target_i != resolve_target_i);
    assign mispredict   = (head_taken_i != resolve_taken_i) ||
                          (head_taken_i && resolve_taken_i && target_diff);

    assign pop_o   = resolve_valid_i;
    assign flush_o = resolve_valid_i && mispredict;

    // A taken outcome predicted not taken or to a stale target refills the BTB
    assign btb_wr_en_o     = resolve_valid_i && resolve_taken_i && (!head_taken_i || target_diff);
    assign btb_wr_class_o  = head_class_i;
    assign btb_wr_target_o = resolve_target_i;

    assign pht_upd_en_o        = resolve_valid_i;
    assign pht_upd_index_o     = head_index_i;
    assign pht_upd_taken_o     = actual_taken;
    assign pht_upd_is_branch_o = (head_class_i == bp_pkg::CLASS_BRANCH);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mispredict_o <= 1'b0;
        end else begin
            mispredict_o <= flush_o;
        end
    end

    always_ff @(posedge clk) begin
        if (flush_o) begin
            redirect_pc_o <= resolve_taken_i ? resolve_target_i : head_pc_i + 32'd4;
        end
    end

endmodule

// File: logic/predict_queue.sv
// In-flight prediction queue
`timescale 1ns/1ps
`include "bp_macros.svh"

module predict_queue (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    push_i,
    input  logic [31:0]             push_pc_i,
    input  bp_pkg::instr_class_e    push_class_i,
    input  logic [`BP_GHR_BITS-1:0] push_index_i,
    input  logic                    push_taken_i,
    input  logic [31:0]             push_target_i,
    input  logic                    pop_i,
    input  logic                    flush_i,
    output logic                    full_o,
    output logic                    empty_o,
    output logic [31:0]             head_pc_o,
    output bp_pkg::instr_class_e    head_class_o,
    output logic [`BP_GHR_BITS-1:0] head_index_o,
    output logic                    head_taken_o,
    output logic [31:0]             head_target_o
);

    localparam int PTR_W = $clog2(`BP_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`BP_QUEUE_DEPTH + 1);

    logic [31:0]             pc_q     [`BP_QUEUE_DEPTH];
    bp_pkg::instr_class_e    class_q  [`BP_QUEUE_DEPTH];
    logic [`BP_GHR_BITS-1:0] index_q  [`BP_QUEUE_DEPTH];
    logic                    taken_q  [`BP_QUEUE_DEPTH];
    logic [31:0]             target_q [`BP_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(`BP_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(`BP_QUEUE_DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Younger entries and any same-cycle push are wrong-path
            rd_ptr_q <= wr_ptr_q;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_q[wr_ptr_q]     <= push_pc_i;
            class_q[wr_ptr_q]  <= push_class_i;
            index_q[wr_ptr_q]  <= push_index_i;
            taken_q[wr_ptr_q]  <= push_taken_i;
            target_q[wr_ptr_q] <= push_target_i;
        end
    end

    assign head_pc_o     = pc_q[rd_ptr_q];
    assign head_class_o  = class_q[rd_ptr_q];
    assign head_index_o  = index_q[rd_ptr_q];
    assign head_taken_o  = taken_q[rd_ptr_q];
    assign head_target_o = target_q[rd_ptr_q];

endmodule

// File: logic/fetch_predictor.sv
// Fetch-side predictor
`timescale 1ns/1ps
`include "bp_macros.svh"

module fetch_predictor (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    fetch_valid_i,
    input  logic [31:0]             fetch_pc_i,
    input  logic [6:0]              fetch_op_i,
    output logic                    fetch_ready_o,
    output logic                    pred_taken_o,
    output logic [31:0]             pred_target_o,
    output logic                    push_o,
    output logic [31:0]             push_pc_o,
    output bp_pkg::instr_class_e    push_class_o,
    output logic [`BP_GHR_BITS-1:0] push_index_o,
    output logic                    push_taken_o,
    output logic [31:0]             push_target_o,
    input  logic                    queue_full_i,
    input  logic                    btb_wr_en_i,
    input  logic [31:0]             btb_wr_pc_i,
    input  bp_pkg::instr_class_e    btb_wr_class_i,
    input  logic [31:0]             btb_wr_target_i,
    input  logic                    pht_upd_en_i,
    input  logic [`BP_GHR_BITS-1:0] pht_upd_index_i,
    input  logic                    pht_upd_taken_i,
    input  logic                    pht_upd_is_branch_i
);

    bp_pkg::instr_class_e    fetch_class;
    logic                    btb_hit;
    bp_pkg::instr_class_e    btb_class;
    logic [31:0]             btb_target;
    logic [`BP_GHR_BITS-1:0] pht_index;
    logic                    pht_taken;

    always_comb begin
        case (fetch_op_i)
            bp_pkg::OPC_BRANCH: fetch_class = bp_pkg::CLASS_BRANCH;
            bp_pkg::OPC_JAL:    fetch_class = bp_pkg::CLASS_JUMP;
            bp_pkg::OPC_JALR:   fetch_class = bp_pkg::CLASS_JUMP;
            default:            fetch_class = bp_pkg::CLASS_NONE;
        endcase
    end

    btb_table btb_table_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .lookup_pc_i  (fetch_pc_i),
        .hit_o        (btb_hit),
        .hit_class_o  (btb_class),
        .hit_target_o (btb_target),
        .wr_en_i      (btb_wr_en_i),
        .wr_pc_i      (btb_wr_pc_i),
        .wr_class_i   (btb_wr_class_i),
        .wr_target_i  (btb_wr_target_i)
    );

    gshare_pht gshare_pht_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .lookup_pc_i     (fetch_pc_i),
        .pht_index_o     (pht_index),
        .predict_taken_o (pht_taken),
        .upd_en_i        (pht_upd_en_i),
        .upd_index_i     (pht_upd_index_i),
        .upd_taken_i     (pht_upd_taken_i),
        .upd_is_branch_i (pht_upd_is_branch_i)
    );

    // Jumps that hit are always taken and branches follow the counter
    assign pred_taken_o = btb_hit && ((btb_class == bp_pkg::CLASS_JUMP) ||
                          ((btb_class == bp_pkg::CLASS_BRANCH) && pht_taken));
    assign pred_target_o = pred_taken_o ? btb_target : fetch_pc_i + 32'd4;

    assign fetch_ready_o = !queue_full_i;
    assign push_o        = fetch_valid_i && (fetch_class != bp_pkg::CLASS_NONE) && fetch_ready_o;
    assign push_pc_o     = fetch_pc_i;
    assign push_class_o  = fetch_class;
    assign push_index_o  = pht_index;
    assign push_taken_o  = pred_taken_o;
    assign push_target_o = pred_target_o;

endmodule

// File: logic/gshare_pht.sv
// Gshare direction predictor
`timescale 1ns/1ps
`include "bp_macros.svh"

module gshare_pht (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [31:0]             lookup_pc_i,
    output logic [`BP_GHR_BITS-1:0] pht_index_o,
    output logic                    predict_taken_o,
    input  logic                    upd_en_i,
    input  logic [`BP_GHR_BITS-1:0] upd_index_i,
    input  logic                    upd_taken_i,
    input  logic                    upd_is_branch_i
);

    localparam int PHT_SIZE = 1 << `BP_GHR_BITS;

    logic [1:0]              pht_q [PHT_SIZE];
    logic [`BP_GHR_BITS-1:0] ghr_q;
    logic [1:0]              upd_cnt;

    assign pht_index_o     = lookup_pc_i[`BP_GHR_BITS+1:2] ^ ghr_q;
    assign predict_taken_o = pht_q[pht_index_o][1];

    assign upd_cnt = pht_q[upd_index_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (upd_en_i && upd_is_branch_i) begin
            // Saturate at both ends
            if (upd_taken_i && (upd_cnt != 2'b11)) begin
                pht_q[upd_index_i] <= upd_cnt + 2'd1;
            end else if (!upd_taken_i && (upd_cnt != 2'b00)) begin
                pht_q[upd_index_i] <= upd_cnt - 2'd1;
            end
        end
    end

    // History only moves at resolution
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (upd_en_i) begin
            ghr_q <= {ghr_q[`BP_GHR_BITS-2:0], upd_taken_i};
        end
    end

endmodule

// File: logic/btb_table.sv
// Branch target buffer
`timescale 1ns/1ps
`include "bp_macros.svh"

module btb_table (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic [31:0]              lookup_pc_i,
    output logic                     hit_o,
    output bp_pkg::instr_class_e     hit_class_o,
    output logic [31:0]              hit_target_o,
    input  logic                     wr_en_i,
    input  logic [31:0]              wr_pc_i,
    input  bp_pkg::instr_class_e     wr_class_i,
    input  logic [31:0]              wr_target_i
);

    localparam int IDX_W = $clog2(`BP_BTB_ENTRIES);

    logic                 valid_q  [`BP_BTB_ENTRIES];
    logic [31:0]          tag_q    [`BP_BTB_ENTRIES];
    bp_pkg::instr_class_e class_q  [`BP_BTB_ENTRIES];
    logic [31:0]          target_q [`BP_BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = lookup_pc_i[IDX_W+1:2];
    assign wr_idx = wr_pc_i[IDX_W+1:2];

    // Full PC is kept as tag, so aliasing never gives a false hit
    assign hit_o        = valid_q[rd_idx] && (tag_q[rd_idx] == lookup_pc_i);
    assign hit_class_o  = hit_o ? class_q[rd_idx] : bp_pkg::CLASS_NONE;
    assign hit_target_o = target_q[rd_idx];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_idx]    <= wr_pc_i;
            class_q[wr_idx]  <= wr_class_i;
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

// File: logic/bp_pkg.sv
// Branch predictor types
package bp_pkg;

    // RISC-V control-transfer opcodes seen at fetch
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } rv_opcode_e;

    // Class kept in BTB and queue entries
    typedef enum logic [1:0] {
        CLASS_NONE   = 2'd0,
        CLASS_BRANCH = 2'd1,
        CLASS_JUMP   = 2'd2
    } instr_class_e;

    // PHT counters are 2-bit saturating and the upper bit means predict taken.
    // They reset to 01 (weakly not taken) and saturate at 00 and 11.

endpackage

// File: logic/bp_macros.svh
// Branch predictor sizes
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// BTB entries, indexed by PC bits 5:2
`define BP_BTB_ENTRIES 16

// Global history length, also sets the PHT size
`define BP_GHR_BITS 4

// In-flight predictions held between fetch and resolve
`define BP_QUEUE_DEPTH 4

`endif
